// File: dbg_access.sv
////////////////////////////////////////////////////////////////////////////
// DMI to memory bridge
// credit counter, single pending entry, outstanding count and the
// result register captured back into the DMI
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "soc_cfg.svh"

module dbg_access import jtag_pkg::*, mem_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     dmi_req_valid_i,
  input  dmi_req_t dmi_req_i,
  input  logic     credit_return_i,
  input  logic     mem_rsp_valid_i,
  input  mem_rsp_t mem_rsp_i,
  output dmi_rsp_t dmi_rsp_o,
  output logic     mem_req_valid_o,
  output mem_req_t mem_req_o
);

  localparam int unsigned CNT_W = $clog2(`SOC_MEM_CREDITS + 1);

  logic [CNT_W-1:0]       credits_q;
  logic [CNT_W-1:0]       outstanding_q;
  logic                   pend_valid_q;
  mem_req_t               pend_q;
  logic                   sticky_busy_q;
  logic [`SOC_ADDR_W-1:0] addr_q;
  mem_rsp_t               result_q;
  logic                   issue;
  logic                   accept;
  logic                   drop;
  logic                   busy;

  // pending entry goes out as soon as a credit is free
  assign issue  = pend_valid_q && (credits_q != '0);
  // slot is free if empty or draining this cycle
  assign accept = dmi_req_valid_i && (!pend_valid_q || issue);
  assign drop   = dmi_req_valid_i && !accept;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      credits_q     <= CNT_W'(`SOC_MEM_CREDITS);
      outstanding_q <= '0;
      pend_valid_q  <= 1'b0;
      sticky_busy_q <= 1'b0;
      addr_q        <= '0;
      result_q      <= '{data: '0, status: MEM_OK};
    end else begin
      credits_q     <= credits_q - CNT_W'(issue) + CNT_W'(credit_return_i);
      outstanding_q <= outstanding_q + CNT_W'(issue) - CNT_W'(mem_rsp_valid_i);
      if (accept) begin
        pend_valid_q <= 1'b1;
      end else if (issue) begin
        pend_valid_q <= 1'b0;
      end
      // lost update stays visible through the following capture
      if (drop) begin
        sticky_busy_q <= 1'b1;
      end else if (accept) begin
        sticky_busy_q <= 1'b0;
      end
      if (accept) begin
        addr_q <= dmi_req_i.addr;
      end
      if (mem_rsp_valid_i) begin
        result_q <= mem_rsp_i;
      end
    end
  end

  // request payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      pend_q.op   <= (dmi_req_i.op == DMI_WRITE) ? MEM_WRITE : MEM_READ;
      pend_q.addr <= dmi_req_i.addr;
      pend_q.data <= dmi_req_i.data;
    end
  end

  assign mem_req_valid_o = issue;
  assign mem_req_o       = pend_q;

  assign busy = (outstanding_q != '0) || pend_valid_q || sticky_busy_q;

  always_comb begin
    dmi_rsp_o.addr   = addr_q;
    dmi_rsp_o.data   = result_q.data;
    dmi_rsp_o.status = busy ? MEM_BUSY : result_q.status;
  end

endmodule

// File: jtag_pkg.sv
////////////////////////////////////////////////////////////////////////////
// JTAG side types: TAP states, instruction codes, DMI request and
// response views and the shared DR word union
////////////////////////////////////////////////////////////////////////////

`include "soc_cfg.svh"

package jtag_pkg;

  localparam int unsigned IR_W = 5;

  // sixteen-state TAP controller
  typedef enum logic [3:0] {
    TEST_LOGIC_RESET,
    RUN_TEST_IDLE,
    SELECT_DR_SCAN,
    CAPTURE_DR,
    SHIFT_DR,
    EXIT1_DR,
    PAUSE_DR,
    EXIT2_DR,
    UPDATE_DR,
    SELECT_IR_SCAN,
    CAPTURE_IR,
    SHIFT_IR,
    EXIT1_IR,
    PAUSE_IR,
    EXIT2_IR,
    UPDATE_IR
  } tap_state_e;

  // unlisted codes behave as bypass
  typedef enum logic [IR_W-1:0] {
    IR_IDCODE     = 5'h01,
    IR_DMI_ACCESS = 5'h11,
    IR_BYPASS     = 5'h1f
  } ir_e;

  typedef enum logic [1:0] {
    DMI_NOP   = 2'd0,
    DMI_READ  = 2'd1,
    DMI_WRITE = 2'd2
  } dmi_op_e;

  // view shifted in
  typedef struct packed {
    logic [`SOC_ADDR_W-1:0] addr;
    logic [`SOC_DATA_W-1:0] data;
    dmi_op_e                op;
  } dmi_req_t;

  // view captured out, status uses the memory status codes
  typedef struct packed {
    logic [`SOC_ADDR_W-1:0] addr;
    logic [`SOC_DATA_W-1:0] data;
    logic [1:0]             status;
  } dmi_rsp_t;

  // one 41-bit DR, read as a request after update and loaded as a response at capture
  typedef union packed {
    dmi_req_t req;
    dmi_rsp_t rsp;
  } dmi_word_u;

endpackage

// File: jtag_tap.sv
////////////////////////////////////////////////////////////////////////////
// JTAG TAP sampled in the system clock domain
// pin synchronizers, tck edge detect, TAP controller, IR and DR shift
// paths (IDCODE, BYPASS, DMI) and tdo drive
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "soc_cfg.svh"

module jtag_tap import jtag_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     jtag_tck_i,
  input  logic     jtag_tms_i,
  input  logic     jtag_tdi_i,
  input  dmi_rsp_t dmi_rsp_i,
  output logic     jtag_tdo_o,
  output logic     jtag_tdo_oe_o,
  output logic     dmi_req_valid_o,
  output dmi_req_t dmi_req_o
);

  localparam int unsigned DMI_W = $bits(dmi_word_u);

  typedef struct packed {
    logic tck;
    logic tms;
    logic tdi;
  } pins_t;

  typedef enum logic [1:0] {
    DR_BYPASS,
    DR_IDCODE,
    DR_DMI
  } dr_sel_e;

  pins_t           pins_meta_q;
  pins_t           pins_q;
  logic            tck_prev_q;
  logic            tck_rise;
  logic            tck_fall;
  tap_state_e      state_q;
  tap_state_e      state_d;
  ir_e             ir_q;
  logic [IR_W-1:0] ir_sr_q;
  logic [31:0]     idcode_sr_q;
  logic            bypass_q;
  dmi_word_u       dmi_sr_q;
  dr_sel_e         dr_sel;
  logic            tdo_bit;
  logic            tdo_q;
  logic            req_valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // pin sampling
  ////////////////////////////////////////////////////////////////////////////

  // two flops per pin, then one more on tck for the edge
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pins_meta_q <= '0;
      pins_q      <= '0;
      tck_prev_q  <= 1'b0;
    end else begin
      pins_meta_q <= '{tck: jtag_tck_i, tms: jtag_tms_i, tdi: jtag_tdi_i};
      pins_q      <= pins_meta_q;
      tck_prev_q  <= pins_q.tck;
    end
  end

  assign tck_rise = pins_q.tck & ~tck_prev_q;
  assign tck_fall = ~pins_q.tck & tck_prev_q;

  ////////////////////////////////////////////////////////////////////////////
  // TAP controller
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (state_q)
      TEST_LOGIC_RESET: state_d = pins_q.tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
      RUN_TEST_IDLE:    state_d = pins_q.tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
      SELECT_DR_SCAN:   state_d = pins_q.tms ? SELECT_IR_SCAN : CAPTURE_DR;
      CAPTURE_DR:       state_d = pins_q.tms ? EXIT1_DR : SHIFT_DR;
      SHIFT_DR:         state_d = pins_q.tms ? EXIT1_DR : SHIFT_DR;
      EXIT1_DR:         state_d = pins_q.tms ? UPDATE_DR : PAUSE_DR;
      PAUSE_DR:         state_d = pins_q.tms ? EXIT2_DR : PAUSE_DR;
      EXIT2_DR:         state_d = pins_q.tms ? UPDATE_DR : SHIFT_DR;
      UPDATE_DR:        state_d = pins_q.tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
      SELECT_IR_SCAN:   state_d = pins_q.tms ? TEST_LOGIC_RESET : CAPTURE_IR;
      CAPTURE_IR:       state_d = pins_q.tms ? EXIT1_IR : SHIFT_IR;
      SHIFT_IR:         state_d = pins_q.tms ? EXIT1_IR : SHIFT_IR;
      EXIT1_IR:         state_d = pins_q.tms ? UPDATE_IR : PAUSE_IR;
      PAUSE_IR:         state_d = pins_q.tms ? EXIT2_IR : PAUSE_IR;
      EXIT2_IR:         state_d = pins_q.tms ? UPDATE_IR : SHIFT_IR;
      UPDATE_IR:        state_d = pins_q.tms ? SELECT_DR_SCAN : RUN_TEST_IDLE;
      default:          state_d = TEST_LOGIC_RESET;
    endcase
  end

  // IR is forced back to IDCODE whenever the controller sits in reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= TEST_LOGIC_RESET;
      ir_q    <= IR_IDCODE;
    end else begin
      if (tck_rise) begin
        state_q <= state_d;
      end
      if (state_q == TEST_LOGIC_RESET) begin
        ir_q <= IR_IDCODE;
      end else if (tck_fall && state_q == UPDATE_IR) begin
        ir_q <= ir_e'(ir_sr_q);
      end
    end
  end

  always_comb begin
    case (ir_q)
      IR_IDCODE:     dr_sel = DR_IDCODE;
      IR_DMI_ACCESS: dr_sel = DR_DMI;
      default:       dr_sel = DR_BYPASS;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // shift paths, lsb first
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (tck_rise) begin
      case (state_q)
        CAPTURE_IR: ir_sr_q <= IR_W'(1);
        SHIFT_IR:   ir_sr_q <= {pins_q.tdi, ir_sr_q[IR_W-1:1]};
        CAPTURE_DR: begin
          idcode_sr_q  <= `SOC_IDCODE;
          bypass_q     <= 1'b0;
          dmi_sr_q.rsp <= dmi_rsp_i;
        end
        SHIFT_DR: begin
          case (dr_sel)
            DR_IDCODE: idcode_sr_q <= {pins_q.tdi, idcode_sr_q[31:1]};
            DR_DMI:    dmi_sr_q    <= dmi_word_u'({pins_q.tdi, dmi_sr_q[DMI_W-1:1]});
            default:   bypass_q    <= pins_q.tdi;
          endcase
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    if (state_q == SHIFT_IR) begin
      tdo_bit = ir_sr_q[0];
    end else begin
      case (dr_sel)
        DR_IDCODE: tdo_bit = idcode_sr_q[0];
        DR_DMI:    tdo_bit = dmi_sr_q[0];
        default:   tdo_bit = bypass_q;
      endcase
    end
  end

  // tdo moves on the falling edge, update fires on the falling edge too
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tdo_q       <= 1'b0;
      req_valid_q <= 1'b0;
    end else begin
      if (tck_fall && (state_q == SHIFT_IR || state_q == SHIFT_DR)) begin
        tdo_q <= tdo_bit;
      end
      req_valid_q <= tck_fall && state_q == UPDATE_DR && dr_sel == DR_DMI &&
                     dmi_sr_q.req.op != DMI_NOP;
    end
  end

  assign jtag_tdo_o      = tdo_q;
  assign jtag_tdo_oe_o   = (state_q == SHIFT_IR) || (state_q == SHIFT_DR);
  assign dmi_req_valid_o = req_valid_q;
  // register is stable while the pulse is high
  assign dmi_req_o       = dmi_sr_q.req;

endmodule

// File: list.f
+incdir+.
jtag_pkg.sv
mem_pkg.sv
jtag_tap.sv
dbg_access.sv
mem_sim.sv
soc_wrapper.sv
soc_assertions.sv
tb_soc_wrapper.sv

// File: mem_pkg.sv
////////////////////////////////////////////////////////////////////////////
// memory side types: operation, status codes, request and response
////////////////////////////////////////////////////////////////////////////

`include "soc_cfg.svh"

package mem_pkg;

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // code 1 is unused
  typedef enum logic [1:0] {
    MEM_OK    = 2'd0,
    MEM_ERROR = 2'd2,
    MEM_BUSY  = 2'd3
  } mem_status_e;

  typedef struct packed {
    mem_op_e                op;
    logic [`SOC_ADDR_W-1:0] addr;
    logic [`SOC_DATA_W-1:0] data;
  } mem_req_t;

  typedef struct packed {
    logic [`SOC_DATA_W-1:0] data;
    mem_status_e            status;
  } mem_rsp_t;

endpackage

// File: mem_sim.sv
////////////////////////////////////////////////////////////////////////////
// simulated word memory
// request slots, fixed-latency response pipe and credit return
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "soc_cfg.svh"

module mem_sim import mem_pkg::*; (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     mem_req_valid_i,
  input  mem_req_t mem_req_i,
  output logic     mem_rsp_valid_o,
  output logic     credit_return_o,
  output mem_rsp_t mem_rsp_o
);

  localparam int unsigned LAT    = `SOC_MEM_LATENCY;
  localparam int unsigned SLOT_W = $clog2(`SOC_MEM_CREDITS + 1);

  logic [`SOC_DATA_W-1:0] mem_q [`SOC_MEM_DEPTH];
  logic [LAT-1:0]         pipe_valid_q;
  mem_rsp_t [LAT-1:0]     pipe_rsp_q;
  logic [SLOT_W-1:0]      slots_used_q;
  logic                   accept;
  logic                   in_range;
  mem_rsp_t               rsp_new;

  // requests beyond the slot count are ignored
  assign accept   = mem_req_valid_i && (slots_used_q < SLOT_W'(`SOC_MEM_CREDITS));
  assign in_range = int'(mem_req_i.addr) < `SOC_MEM_DEPTH;

  // read data is taken at acceptance, before any write in the same cycle lands
  always_comb begin
    rsp_new.data   = '0;
    rsp_new.status = MEM_ERROR;
    if (in_range) begin
      rsp_new.status = MEM_OK;
      if (mem_req_i.op == MEM_READ) begin
        rsp_new.data = mem_q[mem_req_i.addr];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `SOC_MEM_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (accept && in_range && mem_req_i.op == MEM_WRITE) begin
      mem_q[mem_req_i.addr] <= mem_req_i.data;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // response pipe
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pipe_valid_q <= '0;
      slots_used_q <= '0;
    end else begin
      pipe_valid_q[0] <= accept;
      for (int i = 1; i < LAT; i++) begin
        pipe_valid_q[i] <= pipe_valid_q[i-1];
      end
      // a slot frees as its response leaves
      slots_used_q <= slots_used_q + SLOT_W'(accept) - SLOT_W'(pipe_valid_q[LAT-1]);
    end
  end

  always_ff @(posedge clk_i) begin
    pipe_rsp_q[0] <= rsp_new;
    for (int i = 1; i < LAT; i++) begin
      pipe_rsp_q[i] <= pipe_rsp_q[i-1];
    end
  end

  assign mem_rsp_valid_o = pipe_valid_q[LAT-1];
  assign mem_rsp_o       = pipe_rsp_q[LAT-1];
  assign credit_return_o = pipe_valid_q[LAT-1];

endmodule

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_soc_wrapper -o tb_soc_wrapper
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/tb_soc_wrapper > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
  exit 0
fi
echo "pass line not found in $LOG"
exit 1

// File: soc_assertions.sv
////////////////////////////////////////////////////////////////////////////
// concurrent checks bound into the debug bridge
// credit range, no issue without credit, fixed response latency
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "soc_cfg.svh"

module soc_assertions (
  input logic                                      clk_i,
  input logic                                      reset_i,
  input logic [$clog2(`SOC_MEM_CREDITS + 1)-1:0]   credits_i,
  input logic                                      credit_return_i,
  input logic                                      mem_req_valid_i,
  input logic                                      mem_rsp_valid_i
);

  localparam int unsigned CNT_W = $clog2(`SOC_MEM_CREDITS + 1);

  // requests on the memory bus whose credit has not come back yet
  logic [CNT_W-1:0] in_flight_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      in_flight_q <= '0;
    end else begin
      in_flight_q <= in_flight_q + CNT_W'(mem_req_valid_i) - CNT_W'(credit_return_i);
    end
  end

  credit_limit: assert property (@(posedge clk_i) disable iff (reset_i)
    credits_i <= CNT_W'(`SOC_MEM_CREDITS))
    else $error("credit count above the number of memory slots");

  issue_needs_credit: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_valid_i |-> in_flight_q < CNT_W'(`SOC_MEM_CREDITS))
    else $error("memory request issued with no credit left");

  // every request gets its response after the fixed latency
  req_to_rsp: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_req_valid_i |-> ##`SOC_MEM_LATENCY mem_rsp_valid_i)
    else $error("memory response missing at the fixed latency");

  // and no response shows up without a matching request
  rsp_from_req: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_rsp_valid_i |-> $past(mem_req_valid_i, `SOC_MEM_LATENCY))
    else $error("memory response without a request at the fixed latency");

endmodule

// File: soc_cfg.svh
////////////////////////////////////////////////////////////////////////////
// global configuration macros for the debug-access subsystem
// widths, memory size, flow-control credits, latency and JTAG IDCODE
////////////////////////////////////////////////////////////////////////////

`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// word address and data widths
`define SOC_ADDR_W 7
`define SOC_DATA_W 32

// implemented words, anything at or above this decodes to an error
`define SOC_MEM_DEPTH 96

// request slots in the memory model
`define SOC_MEM_CREDITS 2

// cycles from request acceptance to response
`define SOC_MEM_LATENCY 3

// device identification, bit 0 set as JTAG requires
`define SOC_IDCODE 32'h4d5a_c0b1

`endif

// File: soc_wrapper.sv
////////////////////////////////////////////////////////////////////////////
// top level: JTAG TAP, debug bridge and simulated memory
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module soc_wrapper import jtag_pkg::*, mem_pkg::*; (
  input  logic clk_i,
  input  logic reset_i,
  input  logic jtag_tck_i,
  input  logic jtag_tms_i,
  input  logic jtag_tdi_i,
  output logic jtag_tdo_o,
  output logic jtag_tdo_oe_o
);

  // debug front end to bridge
  logic     dmi_req_valid;
  dmi_req_t dmi_req;
  dmi_rsp_t dmi_rsp;

  // bridge to memory
  logic     mem_req_valid;
  mem_req_t mem_req;
  logic     mem_rsp_valid;
  mem_rsp_t mem_rsp;
  logic     credit_return;

  jtag_tap jtag_tap_i (
    .clk_i           ( clk_i         ),
    .reset_i         ( reset_i       ),
    .jtag_tck_i      ( jtag_tck_i    ),
    .jtag_tms_i      ( jtag_tms_i    ),
    .jtag_tdi_i      ( jtag_tdi_i    ),
    .dmi_rsp_i       ( dmi_rsp       ),
    .jtag_tdo_o      ( jtag_tdo_o    ),
    .jtag_tdo_oe_o   ( jtag_tdo_oe_o ),
    .dmi_req_valid_o ( dmi_req_valid ),
    .dmi_req_o       ( dmi_req       )
  );

  dbg_access dbg_access_i (
    .clk_i           ( clk_i         ),
    .reset_i         ( reset_i       ),
    .dmi_req_valid_i ( dmi_req_valid ),
    .dmi_req_i       ( dmi_req       ),
    .credit_return_i ( credit_return ),
    .mem_rsp_valid_i ( mem_rsp_valid ),
    .mem_rsp_i       ( mem_rsp       ),
    .dmi_rsp_o       ( dmi_rsp       ),
    .mem_req_valid_o ( mem_req_valid ),
    .mem_req_o       ( mem_req       )
  );

  // stands in for the DRAM
  mem_sim mem_sim_i (
    .clk_i           ( clk_i         ),
    .reset_i         ( reset_i       ),
    .mem_req_valid_i ( mem_req_valid ),
    .mem_req_i       ( mem_req       ),
    .mem_rsp_valid_o ( mem_rsp_valid ),
    .credit_return_o ( credit_return ),
    .mem_rsp_o       ( mem_rsp       )
  );

endmodule

// File: tb_soc_wrapper.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the debug-access subsystem
// clock and reset, JTAG bit-banging tasks, LFSR stimulus, reference
// memory model, typed compare tasks and the assertion bind
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`include "soc_cfg.svh"

module tb_soc_wrapper import jtag_pkg::*, mem_pkg::*; ();

  localparam int TCK_HALF   = 8;
  localparam int BUSY_LIMIT = 8;
  localparam int DMI_W      = $bits(dmi_req_t);
  localparam int BYP_W      = 24;
  localparam int NUM_WRITES = 12;
  localparam int NUM_MIXED  = 16;
  localparam int NUM_BAD    = 6;

  logic clk_i;
  logic reset_i;
  logic tck;
  logic tms;
  logic tdi;
  logic tdo;
  logic tdo_oe;

  logic [15:0]            lfsr_q;
  logic [`SOC_DATA_W-1:0] ref_mem [`SOC_MEM_DEPTH];
  logic [`SOC_ADDR_W-1:0] written_q [$];
  int                     checks;
  int                     mismatches;
  int                     timeouts;
  bit                     run_done;

  soc_wrapper soc_wrapper_i (
    .clk_i         ( clk_i   ),
    .reset_i       ( reset_i ),
    .jtag_tck_i    ( tck     ),
    .jtag_tms_i    ( tms     ),
    .jtag_tdi_i    ( tdi     ),
    .jtag_tdo_o    ( tdo     ),
    .jtag_tdo_oe_o ( tdo_oe  )
  );

  bind dbg_access soc_assertions soc_assertions_i (
    .clk_i           ( clk_i           ),
    .reset_i         ( reset_i         ),
    .credits_i       ( credits_q       ),
    .credit_return_i ( credit_return_i ),
    .mem_req_valid_i ( mem_req_valid_o ),
    .mem_rsp_valid_i ( mem_rsp_valid_i )
  );

  always #20 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////////////////////
  // random bits and compare tasks
  ////////////////////////////////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  task automatic check_word(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH t=%0t %s got=%08h exp=%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
  endtask

  // data is skipped for in-range writes
  task automatic check_rsp(input string name, input dmi_rsp_t got, input dmi_rsp_t exp,
                           input bit with_data);
    checks++;
    if (got.addr !== exp.addr || got.status !== exp.status ||
        (with_data && got.data !== exp.data)) begin
      mismatches++;
      // values print as addr/data/status
      $display("MISMATCH t=%0t %s got=%02h/%08h/%0d exp=%02h/%08h/%0d",
               $time, name, got.addr, got.data, got.status, exp.addr, exp.data, exp.status);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // JTAG pin tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic wait_clocks(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk_i);
    end
  endtask

  // one tck period with tdo and oe read just before the rising edge
  task automatic tck_step(input logic tms_v, input logic tdi_v, input logic exp_oe,
                          output logic tdo_v);
    tms = tms_v;
    tdi = tdi_v;
    wait_clocks(TCK_HALF);
    tdo_v = tdo;
    check_bit("jtag_tdo_oe_o", tdo_oe, exp_oe);
    tck = 1'b1;
    wait_clocks(TCK_HALF);
    tck = 1'b0;
  endtask

  // starts and ends in run-test/idle
  task automatic dr_scan(input int n, input logic [63:0] din, output logic [63:0] dout);
    logic b;
    dout = '0;
    tck_step(1'b1, 1'b0, 1'b0, b);
    tck_step(1'b0, 1'b0, 1'b0, b);
    tck_step(1'b0, 1'b0, 1'b0, b);
    for (int i = 0; i < n; i++) begin
      tck_step(i == n - 1, din[i], 1'b1, b);
      dout[i] = b;
    end
    tck_step(1'b1, 1'b0, 1'b0, b);
    tck_step(1'b0, 1'b0, 1'b0, b);
  endtask

  task automatic ir_scan(input logic [IR_W-1:0] code, output logic [IR_W-1:0] captured);
    logic b;
    captured = '0;
    tck_step(1'b1, 1'b0, 1'b0, b);
    tck_step(1'b1, 1'b0, 1'b0, b);
    tck_step(1'b0, 1'b0, 1'b0, b);
    tck_step(1'b0, 1'b0, 1'b0, b);
    for (int i = 0; i < IR_W; i++) begin
      tck_step(i == IR_W - 1, code[i], 1'b1, b);
      captured[i] = b;
    end
    tck_step(1'b1, 1'b0, 1'b0, b);
    tck_step(1'b0, 1'b0, 1'b0, b);
  endtask

  task automatic load_ir(input logic [IR_W-1:0] code);
    logic [IR_W-1:0] captured;
    ir_scan(code, captured);
    // capture-IR always loads 00001
    check_word("ir capture", 32'(captured), 32'd1);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // DMI access and reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic dmi_scan(input dmi_req_t req, output dmi_rsp_t rsp);
    logic [63:0] dout;
    dr_scan(DMI_W, 64'(req), dout);
    rsp = dmi_rsp_t'(dout[DMI_W-1:0]);
  endtask

  // nop scans until the bridge stops reporting busy
  task automatic dmi_result(output dmi_rsp_t rsp);
    dmi_req_t nop_req;
    int       tries;
    nop_req = '{addr: '0, data: '0, op: DMI_NOP};
    tries = 0;
    dmi_scan(nop_req, rsp);
    while (rsp.status == 2'(MEM_BUSY) && tries < BUSY_LIMIT) begin
      tries++;
      dmi_scan(nop_req, rsp);
    end
    if (rsp.status == 2'(MEM_BUSY)) begin
      timeouts++;
      $display("t=%0t DMI result still busy after %0d polls", $time, BUSY_LIMIT);
    end
  endtask

  task automatic dmi_access(input dmi_op_e op, input logic [`SOC_ADDR_W-1:0] addr,
                            input logic [`SOC_DATA_W-1:0] data);
    dmi_req_t req;
    dmi_rsp_t rsp;
    dmi_rsp_t exp;
    logic     in_range;
    string    name;
    req = '{addr: addr, data: data, op: op};
    in_range = int'(addr) < `SOC_MEM_DEPTH;
    exp.addr = addr;
    exp.data = '0;
    exp.status = in_range ? 2'(MEM_OK) : 2'(MEM_ERROR);
    if (in_range && op == DMI_READ) begin
      exp.data = ref_mem[addr];
    end
    if (in_range && op == DMI_WRITE) begin
      ref_mem[addr] = data;
    end
    if (op == DMI_WRITE) begin
      name = "dmi write result";
    end else begin
      name = "dmi read result";
    end
    dmi_scan(req, rsp);
    dmi_result(rsp);
    check_rsp(name, rsp, exp, op == DMI_READ || !in_range);
  endtask

  task automatic check_idcode_scan();
    logic [63:0] dout;
    dr_scan(32, 64'(rand_bits(32)), dout);
    check_word("idcode dr", dout[31:0], `SOC_IDCODE);
  endtask

  task automatic check_bypass(input logic [IR_W-1:0] code);
    logic [63:0] din;
    logic [63:0] dout;
    load_ir(code);
    din = 64'(rand_bits(BYP_W));
    dr_scan(BYP_W, din, dout);
    // input delayed by one bit behind the captured zero
    check_word("bypass dr", 32'(dout[BYP_W-1:0]), 32'({din[BYP_W-2:0], 1'b0}));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    logic [IR_W-1:0]        code;
    logic [`SOC_ADDR_W-1:0] addr;
    logic                   b;
    clk_i      = 1'b0;
    reset_i    = 1'b1;
    tck        = 1'b0;
    tms        = 1'b1;
    tdi        = 1'b0;
    lfsr_q     = 16'd61038;
    checks     = 0;
    mismatches = 0;
    timeouts   = 0;
    run_done   = 1'b0;
    for (int i = 0; i < `SOC_MEM_DEPTH; i++) begin
      ref_mem[i] = '0;
    end
    wait_clocks(2);
    reset_i = 1'b0;

    // idcode straight after reset once out of test-logic-reset
    tck_step(1'b0, 1'b0, 1'b0, b);
    check_idcode_scan();

    // bypass and then an unused code
    check_bypass(IR_BYPASS);
    code = IR_W'(rand_bits(IR_W));
    if (code == IR_IDCODE || code == IR_DMI_ACCESS) begin
      code = code ^ 5'h02;
    end
    check_bypass(code);

    load_ir(IR_DMI_ACCESS);
    for (int i = 0; i < NUM_WRITES; i++) begin
      addr = 7'(rand_bits(`SOC_ADDR_W) % `SOC_MEM_DEPTH);
      written_q.push_back(addr);
      dmi_access(DMI_WRITE, addr, rand_bits(`SOC_DATA_W));
    end
    foreach (written_q[i]) begin
      dmi_access(DMI_READ, written_q[i], rand_bits(`SOC_DATA_W));
    end
    for (int i = 0; i < NUM_MIXED; i++) begin
      addr = 7'(rand_bits(`SOC_ADDR_W) % `SOC_MEM_DEPTH);
      if (rand_bits(1) != 0) begin
        dmi_access(DMI_WRITE, addr, rand_bits(`SOC_DATA_W));
      end else begin
        dmi_access(DMI_READ, addr, rand_bits(`SOC_DATA_W));
      end
    end

    // beyond the implemented words
    for (int i = 0; i < NUM_BAD; i++) begin
      addr = 7'(32'(`SOC_MEM_DEPTH) + rand_bits(5));
      if (rand_bits(1) != 0) begin
        dmi_access(DMI_WRITE, addr, rand_bits(`SOC_DATA_W));
      end else begin
        dmi_access(DMI_READ, addr, rand_bits(`SOC_DATA_W));
      end
    end
    foreach (written_q[i]) begin
      dmi_access(DMI_READ, written_q[i], '0);
    end

    // five tms-high clocks reach test-logic-reset from anywhere
    for (int i = 0; i < 5; i++) begin
      tck_step(1'b1, 1'b0, 1'b0, b);
    end
    tck_step(1'b0, 1'b0, 1'b0, b);
    check_idcode_scan();

    $display("checks %0d, mismatches %0d, timeouts %0d", checks, mismatches, timeouts);
    run_done = 1'b1;
    if (mismatches == 0 && timeouts == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  final begin
    if (!run_done) begin
      $display("Regression failed");
    end
  end

endmodule
